// ==== Bender.yml ====
package:
  name: dual_issue_core

sources:
  - common/mips_pkg.sv
  - issue/pair_issue.sv
  - source/alu_lane.sv
  - source/writeback_regs.sv
  - source/dual_issue_core.sv
  - target: test
    files:
      - test/commit_checker.sv
      - test/tb_dual_issue_core.sv

// ==== common/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	localparam int WORD_W = 32;
	localparam int REG_AW = 5;
	localparam int LANES = 2;

	// major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;

	// SPECIAL function field
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2a;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	// same word, two field layouts
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			reg_addr_t  rs;
			reg_addr_t  rt;
			reg_addr_t  rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  opcode;
			reg_addr_t   rs;
			reg_addr_t   rt;
			logic [15:0] imm;
		} i;
	} inst_u;

endpackage

`default_nettype wire

// ==== issue/pair_issue.sv ====
`default_nettype none
`timescale 1ns/1ps

module pair_issue (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        req,
	input  wire mips_pkg::word_t       inst0,
	input  wire mips_pkg::word_t       inst1,
	output logic                       ack,
	output logic [mips_pkg::LANES-1:0] slot_valid,
	output mips_pkg::inst_u            slot_inst [mips_pkg::LANES],
	output mips_pkg::reg_addr_t        rs_addr [mips_pkg::LANES],
	output mips_pkg::reg_addr_t        rt_addr [mips_pkg::LANES]
);
	import mips_pkg::*;

	enum logic [1:0] {IDLE, SECOND, ACK} state, state_next;

	inst_u i0;
	inst_u i1;
	reg_addr_t i0_dest;
	logic split;

	assign i0 = inst0;
	assign i1 = inst1;

	// which register the first word writes, zero if none
	always_comb
	begin
		case (i0.r.opcode)
			OP_SPECIAL:
				i0_dest = i0.r.rd;
			OP_ADDIU, OP_ORI, OP_LUI:
				i0_dest = i0.i.rt;
			default:
				i0_dest = '0;
		endcase
	end

	// rt is only a source for R-type
	assign split = (i0_dest != '0)
		&& ((i0_dest == i1.r.rs) || ((i1.r.opcode == OP_SPECIAL) && (i0_dest == i1.r.rt)));

	always_comb
	begin
		state_next = state;
		slot_valid = '0;
		case (state)
			IDLE:
				if (req)
				begin
					slot_valid[0] = 1'b1;
					slot_valid[1] = !split;
					state_next = split ? SECOND : ACK;
				end
			SECOND:
			begin
				// fetcher holds inst1 stable until ack
				slot_valid[1] = 1'b1;
				state_next = ACK;
			end
			ACK:
				if (!req)
					state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			ack <= 1'b0;
		end
		else
		begin
			state <= state_next;
			ack <= (state_next == ACK);
		end
	end

	assign slot_inst[0] = i0;
	assign slot_inst[1] = i1;

	always_comb
	begin
		for (int k = 0; k < LANES; k++)
		begin
			rs_addr[k] = slot_inst[k].r.rs;
			rt_addr[k] = slot_inst[k].r.rt;
		end
	end

	// the fetcher must keep req up until every word has gone out
	a_issue_needs_req: assert property (@(posedge clk) disable iff (rst)
		!req |-> slot_valid == '0);

endmodule

`default_nettype wire

// ==== list.f ====
common/mips_pkg.sv
issue/pair_issue.sv
source/alu_lane.sv
source/writeback_regs.sv
source/dual_issue_core.sv
test/commit_checker.sv
test/tb_dual_issue_core.sv

// ==== source/alu_lane.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu_lane (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        slot_valid,
	input  wire mips_pkg::inst_u       slot_inst,
	input  wire mips_pkg::word_t       rs_data,
	input  wire mips_pkg::word_t       rt_data,
	input  wire [mips_pkg::LANES-1:0]  fwd_valid,
	input  wire mips_pkg::reg_addr_t   fwd_dest [mips_pkg::LANES],
	input  wire mips_pkg::word_t       fwd_data [mips_pkg::LANES],
	output logic                       res_valid,
	output mips_pkg::reg_addr_t        res_dest,
	output mips_pkg::word_t            res_data
);
	import mips_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t imm_sext;
	word_t imm_zext;
	word_t result;
	reg_addr_t dest;
	logic writes;

	// results from last cycle beat the file, higher lane wins
	always_comb
	begin
		op_a = rs_data;
		op_b = rt_data;
		for (int k = 0; k < LANES; k++)
		begin
			if (fwd_valid[k] && (fwd_dest[k] == slot_inst.r.rs))
				op_a = fwd_data[k];
			if (fwd_valid[k] && (fwd_dest[k] == slot_inst.r.rt))
				op_b = fwd_data[k];
		end
	end

	assign imm_sext = {{(WORD_W-16){slot_inst.i.imm[15]}}, slot_inst.i.imm};
	assign imm_zext = {{(WORD_W-16){1'b0}}, slot_inst.i.imm};

	always_comb
	begin
		result = '0;
		dest = slot_inst.i.rt;
		writes = 1'b1;
		case (slot_inst.r.opcode)
			OP_SPECIAL:
			begin
				dest = slot_inst.r.rd;
				case (slot_inst.r.funct)
					FN_ADDU: result = op_a + op_b;
					FN_SUBU: result = op_a - op_b;
					FN_AND:  result = op_a & op_b;
					FN_OR:   result = op_a | op_b;
					FN_XOR:  result = op_a ^ op_b;
					FN_SLT:  result = {{(WORD_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
					default: writes = 1'b0;
				endcase
			end
			OP_ADDIU: result = op_a + imm_sext;
			OP_ORI:   result = op_a | imm_zext;
			OP_LUI:   result = {slot_inst.i.imm, {(WORD_W-16){1'b0}}};
			default:  writes = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			res_valid <= 1'b0;
		else
			res_valid <= slot_valid && writes && (dest != '0);
		res_dest <= dest;
		res_data <= result;
	end

	a_res_known: assert property (@(posedge clk) disable iff (rst)
		res_valid |-> !$isunknown(res_data));

endmodule

`default_nettype wire

// ==== source/dual_issue_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module dual_issue_core (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        req,
	output logic                       ack,
	input  wire mips_pkg::word_t       inst0,
	input  wire mips_pkg::word_t       inst1,
	output logic [mips_pkg::LANES-1:0] commit_valid,
	output mips_pkg::reg_addr_t        commit_dest [mips_pkg::LANES],
	output mips_pkg::word_t            commit_data [mips_pkg::LANES],
	output mips_pkg::word_t            retired
);
	import mips_pkg::*;

	logic [LANES-1:0] slot_valid;
	inst_u slot_inst [LANES];
	reg_addr_t rs_addr [LANES];
	reg_addr_t rt_addr [LANES];
	reg_addr_t rd_addr [2*LANES];
	word_t rd_data [2*LANES];
	logic [LANES-1:0] res_valid;
	reg_addr_t res_dest [LANES];
	word_t res_data [LANES];

	pair_issue i_pair_issue (
		.clk,
		.rst,
		.req,
		.inst0,
		.inst1,
		.ack,
		.slot_valid,
		.slot_inst,
		.rs_addr,
		.rt_addr
	);

	// each lane owns two file read ports
	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		assign rd_addr[2*i] = rs_addr[i];
		assign rd_addr[2*i+1] = rt_addr[i];

		alu_lane i_alu_lane (
			.clk,
			.rst,
			.slot_valid(slot_valid[i]),
			.slot_inst(slot_inst[i]),
			.rs_data(rd_data[2*i]),
			.rt_data(rd_data[2*i+1]),
			.fwd_valid(res_valid),
			.fwd_dest(res_dest),
			.fwd_data(res_data),
			.res_valid(res_valid[i]),
			.res_dest(res_dest[i]),
			.res_data(res_data[i])
		);
	end

	writeback_regs i_writeback_regs (
		.clk,
		.rst,
		.rd_addr,
		.rd_data,
		.wr_valid(res_valid),
		.wr_dest(res_dest),
		.wr_data(res_data),
		.commit_valid,
		.commit_dest,
		.commit_data,
		.retired
	);

endmodule

`default_nettype wire

// ==== source/writeback_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module writeback_regs (
	input  wire                        clk,
	input  wire                        rst,
	input  wire mips_pkg::reg_addr_t   rd_addr [2*mips_pkg::LANES],
	output mips_pkg::word_t            rd_data [2*mips_pkg::LANES],
	input  wire [mips_pkg::LANES-1:0]  wr_valid,
	input  wire mips_pkg::reg_addr_t   wr_dest [mips_pkg::LANES],
	input  wire mips_pkg::word_t       wr_data [mips_pkg::LANES],
	output logic [mips_pkg::LANES-1:0] commit_valid,
	output mips_pkg::reg_addr_t        commit_dest [mips_pkg::LANES],
	output mips_pkg::word_t            commit_data [mips_pkg::LANES],
	output mips_pkg::word_t            retired
);
	import mips_pkg::*;

	word_t regs [1 << REG_AW];
	word_t retire_inc;

	// register 0 reads as zero
	always_comb
	begin
		for (int k = 0; k < 2*LANES; k++)
			rd_data[k] = (rd_addr[k] == '0) ? '0 : regs[rd_addr[k]];
	end

	always_comb
	begin
		retire_inc = '0;
		for (int k = 0; k < LANES; k++)
			retire_inc = retire_inc + word_t'(wr_valid[k]);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int n = 0; n < (1 << REG_AW); n++)
				regs[n] <= '0;
			retired <= '0;
		end
		else
		begin
			// later lane overwrites, so lane 1 wins on a shared dest
			for (int k = 0; k < LANES; k++)
			begin
				if (wr_valid[k])
					regs[wr_dest[k]] <= wr_data[k];
			end
			retired <= retired + retire_inc;
		end
	end

	// commits are reported in the same cycle as the write
	assign commit_valid = wr_valid;

	always_comb
	begin
		for (int k = 0; k < LANES; k++)
		begin
			commit_dest[k] = wr_dest[k];
			commit_data[k] = wr_data[k];
		end
	end

	a_zero_reg: assert property (@(posedge clk) disable iff (rst)
		regs[0] == '0);

	// lanes drop writes to register 0 before they reach here
	for (genvar k = 0; k < LANES; k++)
	begin : g_chk
		a_no_zero_commit: assert property (@(posedge clk) disable iff (rst)
			wr_valid[k] |-> wr_dest[k] != '0);
	end

endmodule

`default_nettype wire

// ==== test/commit_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module commit_checker (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        ack,
	input  wire [mips_pkg::LANES-1:0]  commit_valid,
	input  wire mips_pkg::reg_addr_t   commit_dest [mips_pkg::LANES],
	input  wire mips_pkg::word_t       commit_data [mips_pkg::LANES],
	input  wire mips_pkg::word_t       retired
);
	import mips_pkg::*;

	// expected commits in program order
	string exp_name [$];
	reg_addr_t exp_dest [$];
	word_t exp_data [$];

	int value_errors = 0;
	int other_errors = 0;
	int seen = 0;

	task automatic expect_commit(input string name, input reg_addr_t dest, input word_t data);
		exp_name.push_back(name);
		exp_dest.push_back(dest);
		exp_data.push_back(data);
	endtask

	task automatic compare_commit(input int lane);
		string name;
		reg_addr_t dest;
		word_t data;
		if (exp_dest.size() == 0)
		begin
			$display("lane %0d committed r%0d = %08h while no commit was expected",
				lane, commit_dest[lane], commit_data[lane]);
			other_errors++;
			return;
		end
		name = exp_name.pop_front();
		dest = exp_dest.pop_front();
		data = exp_data.pop_front();
		seen++;
		if ((commit_dest[lane] !== dest) || (commit_data[lane] !== data))
		begin
			$display("** Error %s: expected r%0d = %08h, actual r%0d = %08h",
				name, dest, data, commit_dest[lane], commit_data[lane]);
			value_errors++;
		end
	endtask

	// lane 0 holds the older instruction when both commit together
	always @(negedge clk)
	begin
		if (!rst)
		begin
			for (int k = 0; k < LANES; k++)
			begin
				if (commit_valid[k] === 1'b1)
					compare_commit(k);
				else if (commit_valid[k] !== 1'b0)
				begin
					$display("commit_valid of lane %0d is unknown", k);
					other_errors++;
				end
			end
		end
	end

	task automatic check_reset_state();
		if (ack !== 1'b0)
		begin
			$display("** Error reset: ack expected 0, actual %b", ack);
			value_errors++;
		end
		if (commit_valid !== '0)
		begin
			$display("** Error reset: commit_valid expected 0, actual %b", commit_valid);
			value_errors++;
		end
		if (retired !== '0)
		begin
			$display("** Error reset: retired expected 0, actual %0d", retired);
			value_errors++;
		end
	endtask

	task automatic check_final(input int total);
		if (exp_dest.size() != 0)
		begin
			$display("%0d expected commits never appeared, first one from %s",
				exp_dest.size(), exp_name[0]);
			other_errors++;
		end
		if (retired !== word_t'(total))
		begin
			$display("** Error retired: expected %0d, actual %0d", total, retired);
			value_errors++;
		end
	endtask

endmodule

`default_nettype wire

// ==== test/tb_dual_issue_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_dual_issue_core;
	import mips_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int CYCLES_PER_ENTRY = 10;

	logic clk;
	logic rst;
	logic req;
	logic ack;
	word_t inst0;
	word_t inst1;
	logic [LANES-1:0] commit_valid;
	reg_addr_t commit_dest [LANES];
	word_t commit_data [LANES];
	word_t retired;

	// stimulus table, one row per instruction pair, dest 0 means no commit
	string t_name [$];
	word_t t_inst0 [$];
	word_t t_inst1 [$];
	reg_addr_t t_dest0 [$];
	word_t t_val0 [$];
	reg_addr_t t_dest1 [$];
	word_t t_val1 [$];

	int n_commits;
	int watchdog_cycles;
	logic table_ready;
	integer seed;

	dual_issue_core i_dual_issue_core (
		.clk,
		.rst,
		.req,
		.ack,
		.inst0,
		.inst1,
		.commit_valid,
		.commit_dest,
		.commit_data,
		.retired
	);

	commit_checker i_checker (
		.clk,
		.rst,
		.ack,
		.commit_valid,
		.commit_dest,
		.commit_data,
		.retired
	);

	initial
		clk = 1'b0;

	always #5 clk = ~clk;

	function automatic word_t rtype(input logic [5:0] funct, input reg_addr_t rd,
		input reg_addr_t rs, input reg_addr_t rt);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic word_t itype(input logic [5:0] op, input reg_addr_t rt,
		input reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic add_entry(input string name, input word_t i0, input word_t i1,
		input reg_addr_t d0, input word_t v0, input reg_addr_t d1, input word_t v1);
		t_name.push_back(name);
		t_inst0.push_back(i0);
		t_inst1.push_back(i1);
		t_dest0.push_back(d0);
		t_val0.push_back(v0);
		t_dest1.push_back(d1);
		t_val1.push_back(v1);
		n_commits += (d0 != '0) + (d1 != '0);
	endtask

	// ADDIU sign-extends and ORI zero-extends, both based on r0
	task automatic add_random_entry(input string name, input reg_addr_t rt0, input reg_addr_t rt1);
		word_t r0;
		word_t r1;
		logic [15:0] imm0;
		logic [15:0] imm1;
		r0 = $random(seed);
		r1 = $random(seed);
		imm0 = r0[15:0];
		imm1 = r1[15:0];
		add_entry(name, itype(OP_ADDIU, rt0, 5'd0, imm0), itype(OP_ORI, rt1, 5'd0, imm1),
			rt0, {{16{imm0[15]}}, imm0}, rt1, {16'h0000, imm1});
	endtask

	task automatic build_table();
		add_entry("load", itype(OP_ADDIU, 1, 0, 16'h0005), itype(OP_ADDIU, 2, 0, 16'hfffd),
			1, 32'h0000_0005, 2, 32'hffff_fffd);
		add_entry("addu_subu", rtype(FN_ADDU, 3, 1, 2), rtype(FN_SUBU, 4, 1, 2),
			3, 32'h0000_0002, 4, 32'h0000_0008);
		add_entry("and_or", rtype(FN_AND, 5, 2, 4), rtype(FN_OR, 6, 1, 4),
			5, 32'h0000_0008, 6, 32'h0000_000d);
		// -3 < 5 only holds as a signed compare
		add_entry("xor_slt", rtype(FN_XOR, 7, 1, 2), rtype(FN_SLT, 8, 2, 1),
			7, 32'hffff_fff8, 8, 32'h0000_0001);
		add_entry("lui_ori", itype(OP_LUI, 9, 0, 16'h8000), itype(OP_ORI, 10, 1, 16'hff00),
			9, 32'h8000_0000, 10, 32'h0000_ff05);
		add_entry("addu_wrap", rtype(FN_ADDU, 11, 9, 9), rtype(FN_SLT, 12, 9, 1),
			11, 32'h0000_0000, 12, 32'h0000_0001);
		add_entry("zero_dest", itype(OP_ADDIU, 0, 1, 16'h0077), rtype(FN_ADDU, 13, 0, 1),
			0, '0, 13, 32'h0000_0005);
		// second word reads the first one's result, so the pair splits
		add_entry("dep_rtype", itype(OP_ADDIU, 14, 1, 16'h0010), rtype(FN_ADDU, 15, 14, 14),
			14, 32'h0000_0015, 15, 32'h0000_002a);
		add_entry("dep_itype", itype(OP_ORI, 16, 0, 16'h1234), itype(OP_ADDIU, 17, 16, 16'hffff),
			16, 32'h0000_1234, 17, 32'h0000_1233);
		add_entry("read_new", rtype(FN_ADDU, 18, 14, 15), rtype(FN_SUBU, 19, 17, 16),
			18, 32'h0000_003f, 19, 32'hffff_ffff);
		add_entry("same_dest", itype(OP_ADDIU, 20, 0, 16'h0011), itype(OP_ADDIU, 20, 0, 16'h0022),
			20, 32'h0000_0011, 20, 32'h0000_0022);
		add_entry("read_same", rtype(FN_OR, 21, 20, 0), 32'hfc01_0000,
			21, 32'h0000_0022, 0, '0);
		add_entry("unknown", rtype(6'h3f, 22, 1, 2), 32'hf800_0000, 0, '0, 0, '0);
		add_random_entry("rand_a", 23, 24);
		add_random_entry("rand_b", 25, 26);
	endtask

	// four-phase handshake for one table row
	task automatic run_pair(input int e);
		if (t_dest0[e] != '0)
			i_checker.expect_commit(t_name[e], t_dest0[e], t_val0[e]);
		if (t_dest1[e] != '0)
			i_checker.expect_commit(t_name[e], t_dest1[e], t_val1[e]);
		inst0 = t_inst0[e];
		inst1 = t_inst1[e];
		req = 1'b1;
		@(negedge clk);
		while (ack !== 1'b1)
			@(negedge clk);
		req = 1'b0;
		@(negedge clk);
		while (ack !== 1'b0)
			@(negedge clk);
	endtask

	initial
	begin
		wait (table_ready);
		repeat (watchdog_cycles) @(posedge clk);
		$display("run timed out after %0d cycles without finishing", watchdog_cycles);
		$display("errors: %0d value, %0d other", i_checker.value_errors,
			i_checker.other_errors + 1);
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		rst = 1'b1;
		req = 1'b0;
		inst0 = '0;
		inst1 = '0;
		table_ready = 1'b0;
		n_commits = 0;
		seed = 32'h91a3_0769;
		build_table();
		// a few extra cycles for the final drain
		watchdog_cycles = t_name.size() * CYCLES_PER_ENTRY + RESET_CYCLES + 10;
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		i_checker.check_reset_state();
		for (int e = 0; e < t_name.size(); e++)
			run_pair(e);
		repeat (3) @(negedge clk);
		i_checker.check_final(n_commits);
		$display("errors: %0d value, %0d other, %0d of %0d commits seen",
			i_checker.value_errors, i_checker.other_errors, i_checker.seen, n_commits);
		if ((i_checker.value_errors == 0) && (i_checker.other_errors == 0))
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
